// File: list.f
+incdir+verif
source/mips_pkg.sv
source/regfile_if.sv
source/stage_reg.sv
source/control.sv
source/registers.sv
source/alu.sv
source/seg_instruction_decode.sv
source/instr_fetch.sv
source/mips_core.sv
verif/tb_mips_core.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mips_core -f list.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^RESULT: PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: verif/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

task automatic build_table();
    // Immediate ops on random operands, sign of a chosen per op
    imm_row("addiu_rand", mips_pkg::OP_ADDIU, 1'b1);
    imm_row("slti_rand", mips_pkg::OP_SLTI, 1'b0);
    imm_row("andi_rand", mips_pkg::OP_ANDI, 1'b1);
    imm_row("ori_rand", mips_pkg::OP_ORI, 1'b0);
    imm_row("xori_rand", mips_pkg::OP_XORI, 1'b1);
    imm_row("lui_rand", mips_pkg::OP_LUI, 1'b0);

    // r1 = fffff0f0, r2 = 00001234
    rtype_row("addu", mips_pkg::FN_ADDU, 5'd0, 32'h0000_0324);
    rtype_row("subu", mips_pkg::FN_SUBU, 5'd0, 32'hffff_debc);
    rtype_row("and", mips_pkg::FN_AND, 5'd0, 32'h0000_1030);
    rtype_row("or", mips_pkg::FN_OR, 5'd0, 32'hffff_f2f4);
    rtype_row("xor", mips_pkg::FN_XOR, 5'd0, 32'hffff_e2c4);
    rtype_row("nor", mips_pkg::FN_NOR, 5'd0, 32'h0000_0d0b);
    rtype_row("slt", mips_pkg::FN_SLT, 5'd0, 32'h0000_0001);
    rtype_row("sll", mips_pkg::FN_SLL, 5'd4, 32'hffff_0f00);
    rtype_row("srl", mips_pkg::FN_SRL, 5'd4, 32'h0fff_ff0f);
    rtype_row("sra", mips_pkg::FN_SRA, 5'd4, 32'hffff_ff0f);   // Sign kept

    // Columns: name, register read back, expected value, program words
    add_row("r0_write", 5'd0, 32'h0,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h1234), NOP, NOP);
    add_row("r0_source", 5'd4, 32'h7,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h1234), NOP,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd4, 16'h0007));

    // J from word 1 to word 3 skips word 2
    add_row("j_squash", 5'd5, 32'h0,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0001),
            jump_instr(mips_pkg::OP_J, 26'd3),
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd5, 16'h0099),
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd6, 16'h0042));
    add_row("j_target", 5'd6, 32'h42,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0001),
            jump_instr(mips_pkg::OP_J, 26'd3),
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd5, 16'h0099),
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd6, 16'h0042));

    // JAL sits at address 4, target is word 4
    add_row("jal_link", 5'd31, 32'h8,
            NOP, jump_instr(mips_pkg::OP_JAL, 26'd4),
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd5, 16'h0055), NOP,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd7, 16'h0077));
    add_row("jal_target", 5'd7, 32'h77,
            NOP, jump_instr(mips_pkg::OP_JAL, 26'd4),
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd5, 16'h0055), NOP,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd7, 16'h0077));

    add_row("before_halt", 5'd1, 32'h5,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0005), HALT_WORD,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'h0009));
    add_row("after_halt", 5'd2, 32'h0,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0005), HALT_WORD,
            imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'h0009));
endtask

`endif

// File: verif/tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;

    localparam int NUM_ROWS    = 24;
    localparam int ROW_WORDS   = 8;
    localparam int HALT_LIMIT  = 24;   // Cycles allowed from run to halted
    localparam int WATCHDOG_NS = NUM_ROWS * 40 * 4;

    localparam mips_pkg::word_t NOP       = 32'h0000_0000;   // sll r0, r0, 0
    localparam mips_pkg::word_t HALT_WORD = {mips_pkg::OP_HALT, 26'd0};

    logic                 clk;
    logic                 rst_n;
    logic                 imem_we;
    mips_pkg::imem_addr_t imem_addr;
    mips_pkg::word_t      imem_data;
    logic                 run;
    logic                 halted;
    mips_pkg::reg_addr_t  dbg_addr;
    mips_pkg::word_t      dbg_data;

    // Stimulus table, one program per row
    string               row_name [NUM_ROWS];
    mips_pkg::word_t     row_prog [NUM_ROWS][ROW_WORDS];
    mips_pkg::reg_addr_t row_reg  [NUM_ROWS];
    mips_pkg::word_t     row_exp  [NUM_ROWS];
    int                  num_rows;

    mips_pkg::word_t lfsr;
    bit              row_ok;
    int              passed;
    int              failed;

    mips_core UUT (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .i_run       (run),
        .o_halted    (halted),
        .i_dbg_addr  (dbg_addr),
        .o_dbg_data  (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic mips_pkg::word_t imm_instr(input logic [5:0] op,
            input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t reg_instr(input logic [5:0] funct,
            input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt,
            input mips_pkg::reg_addr_t rd, input logic [4:0] shamt);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, shamt, funct};
    endfunction

    function automatic mips_pkg::word_t jump_instr(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    // Reference behavior of the I-type instructions
    function automatic mips_pkg::word_t imm_model(input logic [5:0] op,
            input mips_pkg::word_t rs_val, input logic [15:0] imm);
        mips_pkg::word_t se;
        mips_pkg::word_t ze;
        se = {{16{imm[15]}}, imm};
        ze = {16'h0000, imm};
        case (op)
            mips_pkg::OP_ADDIU: return rs_val + se;
            mips_pkg::OP_SLTI:  return ($signed(rs_val) < $signed(se)) ? 32'd1 : 32'd0;
            mips_pkg::OP_ANDI:  return rs_val & ze;
            mips_pkg::OP_ORI:   return rs_val | ze;
            mips_pkg::OP_XORI:  return rs_val ^ ze;
            mips_pkg::OP_LUI:   return {imm, 16'h0000};
            default:            return 32'd0;
        endcase
    endfunction

    task automatic add_row(input string name, input mips_pkg::reg_addr_t r,
            input mips_pkg::word_t exp, input mips_pkg::word_t w0,
            input mips_pkg::word_t w1 = NOP, input mips_pkg::word_t w2 = NOP,
            input mips_pkg::word_t w3 = NOP, input mips_pkg::word_t w4 = NOP,
            input mips_pkg::word_t w5 = NOP, input mips_pkg::word_t w6 = NOP,
            input mips_pkg::word_t w7 = NOP);
        if (num_rows < NUM_ROWS) begin
            row_name[num_rows] = name;
            row_reg[num_rows]  = r;
            row_exp[num_rows]  = exp;
            row_prog[num_rows] = '{w0, w1, w2, w3, w4, w5, w6, w7};
        end
        num_rows++;
    endtask

    // r1 gets sign-extended a, one spacer, then r2 = r1 op b
    // A negative b makes sign and zero extension differ
    task automatic imm_row(input string name, input logic [5:0] op, input logic a_neg);
        logic [15:0] a;
        logic [15:0] b;
        a = rand_bits(15) | {a_neg, 15'd0};
        b = rand_bits(15) | 16'h8000;
        add_row(name, 5'd2, imm_model(op, imm_model(mips_pkg::OP_ADDIU, 32'd0, a), b),
                imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd1, a), NOP,
                imm_instr(op, 5'd1, 5'd2, b));
    endtask

    // Shifts take rt = r1, the others rs = r1 and rt = r2
    task automatic rtype_row(input string name, input logic [5:0] funct,
            input logic [4:0] shamt, input mips_pkg::word_t exp);
        mips_pkg::reg_addr_t src_rt;
        src_rt = (shamt != 5'd0) ? 5'd1 : 5'd2;
        add_row(name, 5'd3, exp,
                imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'hf0f0),
                imm_instr(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'h1234), NOP,
                reg_instr(funct, 5'd1, src_rt, 5'd3, shamt));
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t exp,
            input mips_pkg::word_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            row_ok = 1'b0;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected o_halted %b, actual %b", name, exp, act);
            row_ok = 1'b0;
        end
    endtask

    task automatic check_halt(input string name, input logic done);
        if (done !== 1'b1) begin
            $display("%s: the program did not halt within %0d cycles", name, HALT_LIMIT);
            row_ok = 1'b0;
        end
    endtask

    task automatic run_row(input int idx);
        int waited;
        row_ok = 1'b1;
        @(posedge clk);
        rst_n   <= 1'b0;
        run     <= 1'b0;
        imem_we <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(row_name[idx], 1'b0, halted);

        // Program words, then a HALT behind them
        for (int a = 0; a <= ROW_WORDS; a++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= a[5:0];
            imem_data <= (a == ROW_WORDS) ? HALT_WORD : row_prog[idx][a];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        @(posedge clk);
        run <= 1'b1;

        waited = 0;
        while (halted !== 1'b1 && waited < HALT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_halt(row_name[idx], halted);

        @(posedge clk);
        run      <= 1'b0;
        dbg_addr <= row_reg[idx];
        @(negedge clk);
        if (halted === 1'b1) begin
            check_word(row_name[idx], row_exp[idx], dbg_data);
        end

        if (row_ok) begin
            passed++;
            $display("[%0d] %s ok, r%0d = %h", idx, row_name[idx], row_reg[idx], dbg_data);
        end else begin
            failed++;
            $display("[%0d] %s failed", idx, row_name[idx]);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        run       = 1'b0;
        dbg_addr  = '0;
        lfsr      = 32'h2a68ef0a;
        num_rows  = 0;
        passed    = 0;
        failed    = 0;

        build_table();
        if (num_rows != NUM_ROWS) begin
            $display("Stimulus table holds %0d rows where %0d were expected", num_rows, NUM_ROWS);
            failed++;
        end
        for (int idx = 0; idx < NUM_ROWS; idx++) begin
            run_row(idx);
        end

        $display("Rows passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

`include "tb_programs.svh"

endmodule

`default_nettype wire

// File: source/mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_imem_we,
    input  wire mips_pkg::imem_addr_t i_imem_addr,
    input  wire mips_pkg::word_t      i_imem_data,
    input  wire                       i_run,
    output logic                      o_halted,
    input  wire mips_pkg::reg_addr_t  i_dbg_addr,
    output mips_pkg::word_t           o_dbg_data
);

    // Fetch side
    mips_pkg::if_id_t fetch;
    logic             fetch_valid;
    logic             flush;
    mips_pkg::if_id_t if_id;
    logic             if_id_valid;

    // Decode side
    mips_pkg::id_ex_t decoded;
    logic             jump;
    mips_pkg::word_t  jump_target;
    logic             decode_halt;
    mips_pkg::id_ex_t id_ex;
    logic             id_ex_valid;

    // Execute and writeback
    mips_pkg::ex_wb_t ex_result;
    mips_pkg::ex_wb_t ex_wb;
    logic             ex_wb_valid;
    logic             wb_we;
    logic             wb_halt;

    assign wb_we   = ex_wb_valid && ex_wb.wb.reg_write;
    assign wb_halt = ex_wb_valid && ex_wb.wb.halt;

    instr_fetch u_instr_fetch (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_imem_we     (i_imem_we),
        .i_imem_addr   (i_imem_addr),
        .i_imem_data   (i_imem_data),
        .i_run         (i_run),
        .i_jump        (jump),
        .i_jump_target (jump_target),
        .i_decode_halt (decode_halt),
        .i_wb_halt     (wb_halt),
        .o_fetch       (fetch),
        .o_fetch_valid (fetch_valid),
        .o_flush       (flush),
        .o_halted      (o_halted)
    );

    stage_reg #(.payload_t(mips_pkg::if_id_t)) u_if_id (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (flush),
        .i_valid (fetch_valid),
        .i_data  (fetch),
        .o_valid (if_id_valid),
        .o_data  (if_id)
    );

    seg_instruction_decode u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (if_id_valid),
        .i_fetch       (if_id),
        .i_wb_we       (wb_we),
        .i_wb_dest     (ex_wb.dest),
        .i_wb_data     (ex_wb.result),
        .i_dbg_addr    (i_dbg_addr),
        .o_dbg_data    (o_dbg_data),
        .o_decoded     (decoded),
        .o_jump        (jump),
        .o_jump_target (jump_target),
        .o_halt        (decode_halt)
    );

    stage_reg #(.payload_t(mips_pkg::id_ex_t)) u_id_ex (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (1'b0),
        .i_valid (if_id_valid),
        .i_data  (decoded),
        .o_valid (id_ex_valid),
        .o_data  (id_ex)
    );

    alu u_alu (
        .i_decoded (id_ex),
        .o_result  (ex_result)
    );

    stage_reg #(.payload_t(mips_pkg::ex_wb_t)) u_ex_wb (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (1'b0),
        .i_valid (id_ex_valid),
        .i_data  (ex_result),
        .o_valid (ex_wb_valid),
        .o_data  (ex_wb)
    );

endmodule

`default_nettype wire

// File: source/instr_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module instr_fetch (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  wire                  i_imem_we,
    input  wire mips_pkg::imem_addr_t i_imem_addr,
    input  wire mips_pkg::word_t i_imem_data,
    input  wire                  i_run,
    input  wire                  i_jump,
    input  wire mips_pkg::word_t i_jump_target,
    input  wire                  i_decode_halt,
    input  wire                  i_wb_halt,
    output mips_pkg::if_id_t     o_fetch,
    output logic                 o_fetch_valid,
    output logic                 o_flush,
    output logic                 o_halted
);

    mips_pkg::word_t imem [mips_pkg::IMEM_DEPTH];
    mips_pkg::word_t pc;
    logic            stopped;   // HALT seen in decode

    // Nothing new is issued once HALT sits in decode
    assign o_fetch_valid = i_run && !o_halted && !stopped && !i_decode_halt;
    assign o_flush       = i_jump;   // Kills the word fetched behind the jump

    assign o_fetch.pc    = pc;
    assign o_fetch.instr = imem[pc[7:2]];

    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc       <= '0;
            stopped  <= 1'b0;
            o_halted <= 1'b0;
        end else begin
            if (i_jump) begin
                pc <= i_jump_target;
            end else if (o_fetch_valid) begin
                pc <= pc + 32'd4;
            end
            if (i_decode_halt) stopped <= 1'b1;
            if (i_wb_halt) o_halted <= 1'b1;   // Sticky until reset
        end
    end

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ##1 pc[1:0] == 2'b00);

    a_no_load_while_run: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_run |-> !i_imem_we);

endmodule

`default_nettype wire

// File: source/seg_instruction_decode.sv
`timescale 1ns/10ps
`default_nettype none

module seg_instruction_decode (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_valid,
    input  wire mips_pkg::if_id_t     i_fetch,
    input  wire                       i_wb_we,
    input  wire mips_pkg::reg_addr_t  i_wb_dest,
    input  wire mips_pkg::word_t      i_wb_data,
    input  wire mips_pkg::reg_addr_t  i_dbg_addr,
    output mips_pkg::word_t           o_dbg_data,
    output mips_pkg::id_ex_t          o_decoded,
    output logic                      o_jump,
    output mips_pkg::word_t           o_jump_target,
    output logic                      o_halt
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t rs;
    logic [15:0]         imm;
    mips_pkg::ctrl_ex_t  ctrl_ex;
    mips_pkg::ctrl_wb_t  ctrl_wb;

    regfile_if rf_bus ();

    // Instruction fields
    assign opcode = i_fetch.instr[31:26];
    assign rs     = i_fetch.instr[25:21];
    assign funct  = i_fetch.instr[5:0];
    assign imm    = i_fetch.instr[15:0];

    assign rf_bus.rs_addr = rs;
    assign rf_bus.rt_addr = i_fetch.instr[20:16];

    assign o_decoded.pc      = i_fetch.pc;
    assign o_decoded.rs_data = rf_bus.rs_data;
    assign o_decoded.rt_data = rf_bus.rt_data;
    assign o_decoded.imm_ext = ctrl_ex.zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign o_decoded.shamt   = i_fetch.instr[10:6];
    assign o_decoded.rt      = i_fetch.instr[20:16];
    assign o_decoded.rd      = i_fetch.instr[15:11];
    assign o_decoded.ex      = ctrl_ex;
    assign o_decoded.wb      = ctrl_wb;

    // Jumps resolve here, no delay slot
    assign o_jump        = i_valid && ctrl_ex.jump;
    assign o_jump_target = {i_fetch.pc[31:28], i_fetch.instr[25:0], 2'b00};
    assign o_halt        = i_valid && ctrl_wb.halt;

    control u_control (
        .i_opcode  (opcode),
        .i_funct   (funct),
        .o_ctrl_ex (ctrl_ex),
        .o_ctrl_wb (ctrl_wb)
    );

    registers u_registers (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_we       (i_wb_we),
        .i_dest     (i_wb_dest),
        .i_data     (i_wb_data),
        .rd         (rf_bus.regfile),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data)
    );

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire mips_pkg::id_ex_t i_decoded,
    output mips_pkg::ex_wb_t      o_result
);

    mips_pkg::word_t op_a;
    mips_pkg::word_t op_b;
    logic [4:0]      sh_amt;

    assign op_a   = i_decoded.rs_data;
    assign op_b   = i_decoded.ex.alu_src_imm ? i_decoded.imm_ext : i_decoded.rt_data;
    assign sh_amt = i_decoded.ex.use_shamt ? i_decoded.shamt : op_a[4:0];

    always_comb begin
        case (i_decoded.ex.alu_op)
            mips_pkg::ALU_ADD:       o_result.result = op_a + op_b;
            mips_pkg::ALU_SUB:       o_result.result = op_a - op_b;
            mips_pkg::ALU_AND:       o_result.result = op_a & op_b;
            mips_pkg::ALU_OR:        o_result.result = op_a | op_b;
            mips_pkg::ALU_XOR:       o_result.result = op_a ^ op_b;
            mips_pkg::ALU_NOR:       o_result.result = ~(op_a | op_b);
            mips_pkg::ALU_SLT:       o_result.result = {31'd0, $signed(op_a) < $signed(op_b)};
            mips_pkg::ALU_SLL:       o_result.result = op_b << sh_amt;   // Shifts act on rt
            mips_pkg::ALU_SRL:       o_result.result = op_b >> sh_amt;
            mips_pkg::ALU_SRA:       o_result.result = $signed(op_b) >>> sh_amt;
            mips_pkg::ALU_LUI:       o_result.result = {op_b[15:0], 16'h0000};
            mips_pkg::ALU_PASS_LINK: o_result.result = i_decoded.pc + 32'd4;
            default:                 o_result.result = '0;
        endcase
    end

    // Destination register
    always_comb begin
        if (i_decoded.ex.link) begin
            o_result.dest = 5'd31;
        end else if (i_decoded.ex.reg_dst) begin
            o_result.dest = i_decoded.rd;
        end else begin
            o_result.dest = i_decoded.rt;
        end
    end

    assign o_result.wb = i_decoded.wb;

endmodule

`default_nettype wire

// File: source/registers.sv
`timescale 1ns/10ps
`default_nettype none

module registers (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_we,
    input  wire mips_pkg::reg_addr_t i_dest,
    input  wire mips_pkg::word_t     i_data,
    regfile_if.regfile               rd,
    input  wire mips_pkg::reg_addr_t i_dbg_addr,
    output mips_pkg::word_t          o_dbg_data
);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];
    logic            wr_live;   // Write that actually lands

    assign wr_live = i_we && (i_dest != '0);

    // Same-cycle write passes through to the reads
    assign rd.rs_data = (wr_live && i_dest == rd.rs_addr) ? i_data : regs[rd.rs_addr];
    assign rd.rt_data = (wr_live && i_dest == rd.rt_addr) ? i_data : regs[rd.rt_addr];
    assign o_dbg_data = regs[i_dbg_addr];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_dest] <= i_data;
        end
    end

    // Holds across any sequence of writes aimed at r0
    a_r0_zero_rs: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (rd.rs_addr == '0) |-> (rd.rs_data == '0));

    a_r0_zero_rt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (rd.rt_addr == '0) |-> (rd.rt_data == '0));

endmodule

`default_nettype wire

// File: source/control.sv
`timescale 1ns/10ps
`default_nettype none

module control (
    input  wire [5:0]          i_opcode,
    input  wire [5:0]          i_funct,
    output mips_pkg::ctrl_ex_t o_ctrl_ex,
    output mips_pkg::ctrl_wb_t o_ctrl_wb
);

    always_comb begin
        // Default is a no-op that writes nothing
        o_ctrl_ex        = '0;
        o_ctrl_ex.alu_op = mips_pkg::ALU_ADD;
        o_ctrl_wb        = '0;

        case (i_opcode)
            mips_pkg::OP_RTYPE: begin
                o_ctrl_ex.reg_dst   = 1'b1;
                o_ctrl_wb.reg_write = 1'b1;
                case (i_funct)
                    mips_pkg::FN_ADDU: o_ctrl_ex.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: o_ctrl_ex.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  o_ctrl_ex.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   o_ctrl_ex.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  o_ctrl_ex.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  o_ctrl_ex.alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  o_ctrl_ex.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: begin
                        o_ctrl_ex.alu_op    = mips_pkg::ALU_SLL;
                        o_ctrl_ex.use_shamt = 1'b1;
                    end
                    mips_pkg::FN_SRL: begin
                        o_ctrl_ex.alu_op    = mips_pkg::ALU_SRL;
                        o_ctrl_ex.use_shamt = 1'b1;
                    end
                    mips_pkg::FN_SRA: begin
                        o_ctrl_ex.alu_op    = mips_pkg::ALU_SRA;
                        o_ctrl_ex.use_shamt = 1'b1;
                    end
                    default: o_ctrl_wb.reg_write = 1'b0;   // Unknown funct
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI: begin
                o_ctrl_ex.alu_src_imm = 1'b1;
                o_ctrl_ex.alu_op      = (i_opcode == mips_pkg::OP_SLTI) ?
                                        mips_pkg::ALU_SLT : mips_pkg::ALU_ADD;
                o_ctrl_wb.reg_write   = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                o_ctrl_ex.alu_src_imm = 1'b1;
                o_ctrl_ex.zero_ext    = 1'b1;   // Logical ops zero-extend
                o_ctrl_wb.reg_write   = 1'b1;
                if (i_opcode == mips_pkg::OP_ANDI)     o_ctrl_ex.alu_op = mips_pkg::ALU_AND;
                else if (i_opcode == mips_pkg::OP_ORI) o_ctrl_ex.alu_op = mips_pkg::ALU_OR;
                else                                   o_ctrl_ex.alu_op = mips_pkg::ALU_XOR;
            end
            mips_pkg::OP_LUI: begin
                o_ctrl_ex.alu_src_imm = 1'b1;
                o_ctrl_ex.alu_op      = mips_pkg::ALU_LUI;
                o_ctrl_wb.reg_write   = 1'b1;
            end
            mips_pkg::OP_J: o_ctrl_ex.jump = 1'b1;
            mips_pkg::OP_JAL: begin
                o_ctrl_ex.jump      = 1'b1;
                o_ctrl_ex.link      = 1'b1;   // Destination forced to r31
                o_ctrl_ex.alu_op    = mips_pkg::ALU_PASS_LINK;
                o_ctrl_wb.reg_write = 1'b1;
            end
            mips_pkg::OP_HALT: o_ctrl_wb.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire           i_flush,
    input  wire           i_valid,
    input  wire payload_t i_data,
    output logic          o_valid,
    output payload_t      o_data
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_data <= i_data;   // Payload only meaningful with o_valid
    end

endmodule

`default_nettype wire

// File: source/regfile_if.sv
`timescale 1ns/10ps
`default_nettype none

// Two combinational read ports of the register file
interface regfile_if;

    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;

    modport decode (
        output rs_addr, rt_addr,
        input  rs_data, rt_data
    );

    modport regfile (
        input  rs_addr, rt_addr,
        output rs_data, rt_data
    );

endinterface

`default_nettype wire

// File: source/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int NUM_REGS   = 32;
    localparam int IMEM_DEPTH = 64;   // Instruction memory words

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  imem_addr_t;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    // R-type funct codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_LINK
    } alu_op_t;

    typedef struct packed {
        logic    reg_dst;       // rd instead of rt
        logic    alu_src_imm;
        logic    zero_ext;
        logic    use_shamt;
        logic    jump;
        logic    link;          // Write PC+4 to r31
        alu_op_t alu_op;
    } ctrl_ex_t;

    typedef struct packed {
        logic reg_write;
        logic halt;
    } ctrl_wb_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm_ext;
        logic [4:0] shamt;
        reg_addr_t rt;
        reg_addr_t rd;
        ctrl_ex_t  ex;
        ctrl_wb_t  wb;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t dest;
        ctrl_wb_t  wb;
    } ex_wb_t;

endpackage

`default_nettype wire
